// ==== common/node_bus_pkg.sv ====
`default_nettype none

// ====================
// Bus widths and payload types shared by the host port, router and RAMs
// ====================
package node_bus_pkg;

	localparam int ADDR_W = 32;                   // Byte address width
	localparam int DATA_W = 32;                   // One data word

	typedef logic [ADDR_W-1:0]   addr_t;          // Byte address
	typedef logic [DATA_W-1:0]   data_t;          // Data word
	typedef logic [DATA_W/8-1:0] sel_t;           // One strobe per byte lane

	// Interrupt side of the node
	typedef logic [7:0] cause_t;                  // Cause code delivered with a level
	typedef logic [2:0] irq_level_t;              // Level zero means no interrupt

	// Response codes as they appear on BRESP and RRESP
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// Target of a decoded host address
	typedef enum logic [1:0] {
		SHARED,                                   // RAM shared with the network port
		SCRATCH,                                  // Host-only scratchpad
		CAUSE,                                    // Interrupt cause table
		NONE                                      // Unmapped, answered with an error
	} region_e;

endpackage

`default_nettype wire

// ==== common/node_map_pkg.sv ====
`default_nettype none

// ====================
// Address map of the node
// ====================
package node_map_pkg;

	// The window number sits in address bits 31 down to REGION_LSB
	localparam int REGION_LSB = 18;               // 256 KB per window
	localparam int WIN_W      = 14;               // Bits from REGION_LSB to the top of the address
	localparam int WORD_LSB   = 2;                // Word index starts above the byte offset

	typedef logic [WIN_W-1:0] win_t;

	// Decoded windows, anything else is unmapped
	localparam win_t SHARED_WIN  = win_t'(0);
	localparam win_t SCRATCH_WIN = win_t'(1);
	localparam win_t CAUSE_WIN   = win_t'(2);

endpackage

`default_nettype wire

// ==== common/local_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One request and its response inside the node
// The master holds req and the request fields until ack, then drops req the next cycle
interface local_bus_if;
	import node_bus_pkg::*;

	// Request side, owned by the master
	logic  req;
	logic  we;                                    // High for a write
	addr_t adr;
	data_t wdata;
	sel_t  sel;                                   // Byte strobes for writes

	// Response side, owned by the slave
	logic  ack;                                   // One-cycle pulse ending the request
	data_t rdata;                                 // Valid with ack
	logic  err;                                   // Valid with ack

	modport master (
		output req, we, adr, wdata, sel,
		input  ack, rdata, err
	);

	modport slave (
		input  req, we, adr, wdata, sel,
		output ack, rdata, err
	);

endinterface

`default_nettype wire

// ==== design/host_port/axil_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

// AXI4-Lite slave that turns each transaction into one local-bus request
module axil_slave (
	input  wire                  clk,
	input  wire                  rst_i,
	// Write address and data
	input  wire node_bus_pkg::addr_t s_awaddr_i,
	input  wire                  s_awvalid_i,
	output logic                 s_awready_o,
	input  wire node_bus_pkg::data_t s_wdata_i,
	input  wire node_bus_pkg::sel_t  s_wstrb_i,
	input  wire                  s_wvalid_i,
	output logic                 s_wready_o,
	// Write response
	output node_bus_pkg::resp_e  s_bresp_o,
	output logic                 s_bvalid_o,
	input  wire                  s_bready_i,
	// Read address and data
	input  wire node_bus_pkg::addr_t s_araddr_i,
	input  wire                  s_arvalid_i,
	output logic                 s_arready_o,
	output node_bus_pkg::data_t  s_rdata_o,
	output node_bus_pkg::resp_e  s_rresp_o,
	output logic                 s_rvalid_o,
	input  wire                  s_rready_i,
	// Local bus towards the router
	local_bus_if.master          bus_o
);
	import node_bus_pkg::*;

	typedef enum logic [2:0] {IDLE, WRITE, READ, BRESP, RRESP} state_e;

	state_e state_q;
	addr_t  adr_q;                                // Latched AWADDR or ARADDR
	data_t  wdata_q;
	sel_t   sel_q;
	data_t  rdata_q;                              // Response held until the master takes it
	resp_e  resp_q;
	logic   wr_take;
	logic   rd_take;

	// ====================
	// Address channel acceptance
	// ====================
	// A write needs address and data together, and wins over a read in the same cycle
	assign wr_take = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
	assign rd_take = (state_q == IDLE) && s_arvalid_i && !wr_take;

	assign s_awready_o = wr_take;
	assign s_wready_o  = wr_take;
	assign s_arready_o = (state_q == IDLE) && !(s_awvalid_i && s_wvalid_i); // Held off while a write is taken

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (wr_take) begin
						state_q <= WRITE;
					end else if (rd_take) begin
						state_q <= READ;
					end
				end
				WRITE: if (bus_o.ack) state_q <= BRESP;
				READ:  if (bus_o.ack) state_q <= RRESP;
				BRESP: if (s_bready_i) state_q <= IDLE; // Stays busy under back-pressure
				RRESP: if (s_rready_i) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Request fields and the captured response
	always_ff @(posedge clk) begin
		if (wr_take) begin
			adr_q   <= s_awaddr_i;
			wdata_q <= s_wdata_i;
			sel_q   <= s_wstrb_i;
		end else if (rd_take) begin
			adr_q <= s_araddr_i;
			sel_q <= '1;                          // Reads cover the whole word
		end
		if (bus_o.ack) begin
			rdata_q <= bus_o.rdata;
			resp_q  <= bus_o.err ? SLVERR : OKAY;
		end
	end

	// ====================
	// Local request and AXI responses
	// ====================
	assign bus_o.req   = (state_q == WRITE) || (state_q == READ);
	assign bus_o.we    = (state_q == WRITE);
	assign bus_o.adr   = adr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.sel   = sel_q;

	assign s_bvalid_o = (state_q == BRESP);
	assign s_bresp_o  = resp_q;
	assign s_rvalid_o = (state_q == RRESP);
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = resp_q;

endmodule

`default_nettype wire

// ==== design/node_region_router.sv ====
`timescale 1ns/100ps
`default_nettype none

// Steers a host request to the shared RAM, the scratchpad or the cause table
module node_region_router (
	input  wire         clk,
	input  wire         rst_i,
	local_bus_if.slave  host_i,                   // From the AXI4-Lite port
	local_bus_if.master shared_o,                 // Host side of the shared RAM arbiter
	local_bus_if.master scratch_o,
	local_bus_if.master cause_o
);
	import node_bus_pkg::*;
	import node_map_pkg::*;

	win_t    win;
	region_e region;
	logic    none_ack_q;                          // Error ack for unmapped addresses

	// Address is held by the master until ack, so the decode stays stable for the response
	assign win = host_i.adr[REGION_LSB +: WIN_W];

	always_comb begin
		case (win)
			SHARED_WIN:  region = SHARED;
			SCRATCH_WIN: region = SCRATCH;
			CAUSE_WIN:   region = CAUSE;
			default:     region = NONE;
		endcase
	end

	// ====================
	// Request fan-out
	// ====================
	// Fields go to every target, only the decoded one sees req
	assign shared_o.req   = host_i.req && (region == SHARED);
	assign shared_o.we    = host_i.we;
	assign shared_o.adr   = host_i.adr;
	assign shared_o.wdata = host_i.wdata;
	assign shared_o.sel   = host_i.sel;

	assign scratch_o.req   = host_i.req && (region == SCRATCH);
	assign scratch_o.we    = host_i.we;
	assign scratch_o.adr   = host_i.adr;
	assign scratch_o.wdata = host_i.wdata;
	assign scratch_o.sel   = host_i.sel;

	assign cause_o.req   = host_i.req && (region == CAUSE);
	assign cause_o.we    = host_i.we;
	assign cause_o.adr   = host_i.adr;
	assign cause_o.wdata = host_i.wdata;
	assign cause_o.sel   = host_i.sel;

	// Unmapped request answered one cycle after req, once
	always_ff @(posedge clk) begin
		if (rst_i) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= host_i.req && (region == NONE) && !none_ack_q;
		end
	end

	// ====================
	// Response return
	// ====================
	assign host_i.ack = shared_o.ack | scratch_o.ack | cause_o.ack | none_ack_q; // Only one can fire

	always_comb begin
		case (region)
			SHARED: begin
				host_i.rdata = shared_o.rdata;
				host_i.err   = shared_o.err;
			end
			SCRATCH: begin
				host_i.rdata = scratch_o.rdata;
				host_i.err   = scratch_o.err;
			end
			CAUSE: begin
				host_i.rdata = cause_o.rdata;
				host_i.err   = cause_o.err;
			end
			default: begin
				host_i.rdata = '0;                // Unmapped reads return zero
				host_i.err   = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/shared_ram/shared_ram_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Round-robin arbiter between the host and the network port on the shared RAM
module shared_ram_arbiter (
	input  wire                      clk,
	input  wire                      rst_i,
	local_bus_if.slave               host_i,     // Host requests from the router
	// Network master port
	input  wire                      net_req_i,
	input  wire                      net_we_i,
	input  wire node_bus_pkg::addr_t net_adr_i,
	input  wire node_bus_pkg::data_t net_wdata_i,
	input  wire node_bus_pkg::sel_t  net_sel_i,
	output logic                     net_ack_o,
	output node_bus_pkg::data_t      net_rdata_o,
	local_bus_if.master              ram_o       // Towards the shared byte RAM
);

	typedef enum logic [1:0] {IDLE, HOST, NET} state_e;

	state_e state_q;
	logic   last_net_q;                           // Set when the network was served last

	// ====================
	// Grant FSM
	// ====================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= IDLE;
			last_net_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					// On a tie the requester not served last wins
					if (host_i.req && (!net_req_i || last_net_q)) begin
						state_q    <= HOST;
						last_net_q <= 1'b0;
					end else if (net_req_i) begin
						state_q    <= NET;
						last_net_q <= 1'b1;
					end
				end
				HOST, NET: begin
					if (ram_o.ack) begin
						state_q <= IDLE;          // Grant ends with the RAM ack
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Request mux, the granted side drives the RAM
	always_comb begin
		ram_o.req   = 1'b0;
		ram_o.we    = host_i.we;
		ram_o.adr   = host_i.adr;
		ram_o.wdata = host_i.wdata;
		ram_o.sel   = host_i.sel;
		case (state_q)
			HOST: ram_o.req = host_i.req;
			NET: begin
				ram_o.req   = net_req_i;
				ram_o.we    = net_we_i;
				ram_o.adr   = net_adr_i;      // RAM takes the word index from bits 2 up
				ram_o.wdata = net_wdata_i;
				ram_o.sel   = net_sel_i;
			end
			default: ram_o.req = 1'b0;
		endcase
	end

	// ====================
	// Ack return to the grant holder
	// ====================
	assign host_i.ack   = (state_q == HOST) && ram_o.ack;
	assign host_i.rdata = ram_o.rdata;
	assign host_i.err   = ram_o.err;
	assign net_ack_o    = (state_q == NET) && ram_o.ack;
	assign net_rdata_o  = ram_o.rdata;

endmodule

`default_nettype wire

// ==== design/byte_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// Single-port RAM with byte writes and an ack READ_LATENCY cycles after the request
module byte_ram #(
	parameter int WORDS        = 1024,            // Power of two, index wraps modulo depth
	parameter int READ_LATENCY = 2
) (
	input  wire        clk,
	input  wire        rst_i,
	local_bus_if.slave bus_i
);
	import node_bus_pkg::*;
	import node_map_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	data_t                   mem [WORDS];
	data_t                   data_q [READ_LATENCY]; // Read data pipeline
	logic [READ_LATENCY-1:0] valid_q;             // Marks the request moving with the data
	logic [IDX_W-1:0]        idx;
	logic                    take;

	assign idx  = bus_i.adr[WORD_LSB +: IDX_W];
	assign take = bus_i.req && !(|valid_q);       // A held request is taken once

	// Read-first access, old word goes into the pipeline
	always_ff @(posedge clk) begin
		if (take) begin
			data_q[0] <= mem[idx];
			for (int b = 0; b < $bits(sel_t); b++) begin
				if (bus_i.we && bus_i.sel[b]) begin
					mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
				end
			end
		end
		for (int s = 1; s < READ_LATENCY; s++) begin
			data_q[s] <= data_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= take;
			for (int s = 1; s < READ_LATENCY; s++) begin
				valid_q[s] <= valid_q[s-1];
			end
		end
	end

	assign bus_i.ack   = valid_q[READ_LATENCY-1]; // Writes are acked the same way
	assign bus_i.rdata = data_q[READ_LATENCY-1];
	assign bus_i.err   = 1'b0;

endmodule

`default_nettype wire

// ==== design/irq_cause_table.sv ====
`timescale 1ns/100ps
`default_nettype none

// Eight interrupt cause entries, one per level, readable by the host
module irq_cause_table (
	input  wire                          clk,
	input  wire                          rst_i,
	input  wire node_bus_pkg::irq_level_t irq_level_i,
	input  wire node_bus_pkg::cause_t     irq_cause_i,
	local_bus_if.slave                   bus_i
);
	import node_bus_pkg::*;
	import node_map_pkg::*;

	localparam int ENTRIES = 2 ** $bits(irq_level_t);

	cause_t     entry_q [ENTRIES];
	irq_level_t idx;
	logic       ack_q;
	data_t      rdata_q;
	logic       take;

	assign idx  = bus_i.adr[WORD_LSB +: $bits(irq_level_t)];
	assign take = bus_i.req && !ack_q;            // Answered one cycle after req

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				entry_q[i] <= '0;
			end
			ack_q <= 1'b0;
		end else begin
			ack_q <= take;
			if (take && bus_i.we && bus_i.sel[0]) begin
				entry_q[idx] <= bus_i.wdata[$bits(cause_t)-1:0];
			end
			// Capture comes last so it wins, level zero never captures
			if (irq_level_i != '0) begin
				entry_q[irq_level_i] <= irq_cause_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rdata_q <= data_t'(entry_q[idx]);     // Zero-extended
		end
	end

	assign bus_i.ack   = ack_q;
	assign bus_i.rdata = rdata_q;
	assign bus_i.err   = 1'b0;

endmodule

`default_nettype wire

// ==== design/node_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// Memory side of a processing node with host, network and interrupt inputs
module node_mem_top #(
	parameter int SHARED_WORDS  = 1024,
	parameter int SCRATCH_WORDS = 256,
	parameter int READ_LATENCY  = 2
) (
	input  wire                          clk,
	input  wire                          rst_i,
	// ====================
	// AXI4-Lite host port
	input  wire node_bus_pkg::addr_t     s_awaddr_i,
	input  wire                          s_awvalid_i,
	output logic                         s_awready_o,
	input  wire node_bus_pkg::data_t     s_wdata_i,
	input  wire node_bus_pkg::sel_t      s_wstrb_i,
	input  wire                          s_wvalid_i,
	output logic                         s_wready_o,
	output node_bus_pkg::resp_e          s_bresp_o,
	output logic                         s_bvalid_o,
	input  wire                          s_bready_i,
	input  wire node_bus_pkg::addr_t     s_araddr_i,
	input  wire                          s_arvalid_i,
	output logic                         s_arready_o,
	output node_bus_pkg::data_t          s_rdata_o,
	output node_bus_pkg::resp_e          s_rresp_o,
	output logic                         s_rvalid_o,
	input  wire                          s_rready_i,
	// ====================
	// Network master port, always the shared RAM
	input  wire                          net_req_i,
	input  wire                          net_we_i,
	input  wire node_bus_pkg::addr_t     net_adr_i,
	input  wire node_bus_pkg::data_t     net_wdata_i,
	input  wire node_bus_pkg::sel_t      net_sel_i,
	output logic                         net_ack_o,
	output node_bus_pkg::data_t          net_rdata_o,
	// Interrupt level and cause
	input  wire node_bus_pkg::irq_level_t irq_level_i,
	input  wire node_bus_pkg::cause_t     irq_cause_i
);

	local_bus_if host_bus ();                     // AXI slave to router
	local_bus_if shared_host_bus ();              // Router to arbiter
	local_bus_if scratch_bus ();
	local_bus_if cause_bus ();
	local_bus_if shared_ram_bus ();               // Arbiter to shared RAM

	axil_slave u_axil_slave (
		.clk, .rst_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.bus_o     (host_bus)
	);

	node_region_router u_router (
		.clk, .rst_i,
		.host_i    (host_bus),
		.shared_o  (shared_host_bus),
		.scratch_o (scratch_bus),
		.cause_o   (cause_bus)
	);

	shared_ram_arbiter u_arbiter (
		.clk, .rst_i,
		.host_i    (shared_host_bus),
		.net_req_i, .net_we_i, .net_adr_i, .net_wdata_i, .net_sel_i,
		.net_ack_o, .net_rdata_o,
		.ram_o     (shared_ram_bus)
	);

	byte_ram #(.WORDS(SHARED_WORDS), .READ_LATENCY(READ_LATENCY)) u_shared_ram (
		.clk, .rst_i,
		.bus_i     (shared_ram_bus)
	);

	byte_ram #(.WORDS(SCRATCH_WORDS), .READ_LATENCY(READ_LATENCY)) u_scratch_ram (
		.clk, .rst_i,
		.bus_i     (scratch_bus)
	);

	irq_cause_table u_cause_table (
		.clk, .rst_i,
		.irq_level_i, .irq_cause_i,
		.bus_i     (cause_bus)
	);

endmodule

`default_nettype wire

// ==== sim/node_mem_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

// Handshake rules on the top-level ports, checked only while out of reset
module node_mem_properties (
	input wire                      clk,
	input wire                      rst_i,
	// AXI4-Lite write side
	input wire                      awvalid_i,
	input wire                      wvalid_i,
	input wire                      awready_i,
	input wire                      bvalid_i,
	input wire                      bready_i,
	input wire node_bus_pkg::resp_e bresp_i,
	// AXI4-Lite read side
	input wire                      rvalid_i,
	input wire                      rready_i,
	input wire node_bus_pkg::data_t rdata_i,
	input wire node_bus_pkg::resp_e rresp_i,
	// Network port
	input wire                      net_ack_i
);

	// Write response stays up with the same code until bready takes it
	bvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else $error("bvalid dropped or bresp changed before bready");

	rvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
		else $error("rvalid dropped or read payload changed before rready");

	// The network ack never lasts longer than one cycle
	net_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
		net_ack_i |=> !net_ack_i)
		else $error("net_ack_o high for more than one cycle");

	awready_needs_both: assert property (@(posedge clk) disable iff (rst_i)
		awready_i |-> awvalid_i && wvalid_i)                  // Address and data go in together
		else $error("awready high without both awvalid and wvalid");

endmodule

bind node_mem_top node_mem_properties u_properties (
	.clk       (clk),
	.rst_i     (rst_i),
	.awvalid_i (s_awvalid_i),
	.wvalid_i  (s_wvalid_i),
	.awready_i (s_awready_o),
	.bvalid_i  (s_bvalid_o),
	.bready_i  (s_bready_i),
	.bresp_i   (s_bresp_o),
	.rvalid_i  (s_rvalid_o),
	.rready_i  (s_rready_i),
	.rdata_i   (s_rdata_o),
	.rresp_i   (s_rresp_o),
	.net_ack_i (net_ack_o)
);

`default_nettype wire

// ==== sim/tb_node_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

// Directed testbench for the node memory, host port over AXI4-Lite plus the network port
module tb_node_mem;
	import node_bus_pkg::*;

	localparam int     TIMEOUT_CYCLES = 100;          // Upper bound on any single wait
	localparam logic [15:0] LFSR_TAPS = 16'hB400;     // x^16 + x^14 + x^13 + x^11 + 1
	localparam addr_t  SCRATCH_BASE   = 32'h0004_0000; // Window 1
	localparam addr_t  CAUSE_BASE     = 32'h0008_0000; // Window 2
	localparam addr_t  UNMAPPED_BASE  = 32'h000C_0000; // Window 3 has no target

	// Which output a wait loop watches
	localparam int AWREADY = 0;
	localparam int ARREADY = 1;
	localparam int BVALID  = 2;
	localparam int RVALID  = 3;
	localparam int NET_ACK = 4;

	logic       clk = 1'b0;
	logic       rst_i;
	addr_t      s_awaddr_i, s_araddr_i, net_adr_i;
	data_t      s_wdata_i, net_wdata_i, s_rdata_o, net_rdata_o;
	sel_t       s_wstrb_i, net_sel_i;
	logic       s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
	logic       s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
	resp_e      s_bresp_o, s_rresp_o;
	logic       net_req_i, net_we_i, net_ack_o;
	irq_level_t irq_level_i;
	cause_t     irq_cause_i;

	int          errors = 0;
	int          timeouts = 0;
	logic [15:0] lfsr_q = 16'd52533;

	node_mem_top dut (.*);

	always #5 clk = ~clk;                             // 10 ns period

	// ====================
	// Helpers
	// ====================
	// One LFSR step per bit taken, the newest bit lands in bit 0
	function automatic data_t lfsr_bits(input int count);
		data_t word;
		logic  bit_out;
		word = '0;
		for (int i = 0; i < count; i++) begin
			bit_out = lfsr_q[0];
			lfsr_q  = (lfsr_q >> 1) ^ (bit_out ? LFSR_TAPS : 16'h0);
			word    = {word[$bits(data_t)-2:0], bit_out};
		end
		return word;
	endfunction

	function automatic data_t random_word();
		return lfsr_bits($bits(data_t));
	endfunction

	// Bytes with a strobe set come from the new word, the rest keep the old one
	function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
		input sel_t strb);
		data_t merged;
		merged = old_word;
		for (int b = 0; b < $bits(sel_t); b++) begin
			if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	// Outputs are sampled on the falling edge, halfway between drive edges
	task automatic await_high(input int which, input string what);
		int   waited;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
			case (which)
				AWREADY: seen = s_awready_o;
				ARREADY: seen = s_arready_o;
				BVALID:  seen = s_bvalid_o;
				RVALID:  seen = s_rvalid_o;
				NET_ACK: seen = net_ack_o;
				default: seen = 1'b0;
			endcase
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout: %s did not go high within %0d cycles", what, TIMEOUT_CYCLES);
		end
	endtask

	task automatic check_data(input string test, input data_t exp, input data_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", test, exp, act);
		end
	endtask

	task automatic check_resp(input string test, input resp_e exp, input resp_e act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected resp %h, actual resp %h", test, exp, act);
		end
	endtask

	task automatic check_cause(input string test, input cause_t exp, input cause_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected cause %h, actual cause %h", test, exp, act);
		end
	endtask

	// ====================
	// Bus transactions
	// ====================
	task automatic axil_write(input addr_t addr, input data_t data, input sel_t strb,
		input int ready_delay, output resp_e resp);
		@(posedge clk);
		s_awaddr_i  <= addr;
		s_wdata_i   <= data;
		s_wstrb_i   <= strb;
		s_awvalid_i <= 1'b1;
		s_wvalid_i  <= 1'b1;
		await_high(AWREADY, "awready");
		if (s_wready_o !== 1'b1) begin                    // Both channels are taken in one cycle
			errors++;
			$display("wready did not rise together with awready");
		end
		@(posedge clk);                                   // Address and data accepted here
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		await_high(BVALID, "bvalid");
		repeat (ready_delay) begin
			@(negedge clk);
			if (!s_bvalid_o) begin
				errors++;
				$display("Write response withdrawn while bready was low");
			end
		end
		resp = s_bresp_o;
		@(posedge clk);
		s_bready_i <= 1'b1;
		@(posedge clk);
		s_bready_i <= 1'b0;
	endtask

	task automatic axil_read(input addr_t addr, input int ready_delay, output data_t data,
		output resp_e resp);
		@(posedge clk);
		s_araddr_i  <= addr;
		s_arvalid_i <= 1'b1;
		await_high(ARREADY, "arready");
		@(posedge clk);
		s_arvalid_i <= 1'b0;
		await_high(RVALID, "rvalid");
		repeat (ready_delay) begin
			@(negedge clk);
			if (!s_rvalid_o) begin
				errors++;
				$display("Read response withdrawn while rready was low");
			end
		end
		data = s_rdata_o;
		resp = s_rresp_o;
		@(posedge clk);
		s_rready_i <= 1'b1;
		@(posedge clk);
		s_rready_i <= 1'b0;
	endtask

	// Request and fields held until the one-cycle ack
	task automatic net_access(input logic we, input addr_t adr, input data_t wdata,
		input sel_t sel, output data_t rdata);
		@(posedge clk);
		net_req_i   <= 1'b1;
		net_we_i    <= we;
		net_adr_i   <= adr;
		net_wdata_i <= wdata;
		net_sel_i   <= sel;
		await_high(NET_ACK, "net_ack_o");
		rdata = net_rdata_o;
		@(posedge clk);
		net_req_i <= 1'b0;
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_strobe_merge();
		data_t full, part, rd;
		resp_e resp;
		full = random_word();
		part = random_word();
		axil_write(32'h40, full, 4'hF, 0, resp);
		check_resp("strobe full write", OKAY, resp);
		axil_write(32'h40, part, 4'b0101, 0, resp);
		check_resp("strobe partial write", OKAY, resp);
		axil_read(32'h40, 0, rd, resp);
		check_resp("strobe read", OKAY, resp);
		check_data("strobe read", merge_bytes(full, part, 4'b0101), rd);
	endtask

	task automatic test_region_independence();
		data_t a, b, rd;
		resp_e resp;
		a = random_word();
		b = random_word();
		axil_write(32'h80, a, 4'hF, 0, resp);
		axil_write(SCRATCH_BASE + 32'h80, b, 4'hF, 0, resp);
		check_resp("scratch write", OKAY, resp);
		axil_read(32'h80, 0, rd, resp);
		check_data("shared keeps value", a, rd);
		axil_read(SCRATCH_BASE + 32'h80, 0, rd, resp);
		check_resp("scratch read", OKAY, resp);
		check_data("scratch keeps value", b, rd);
	endtask

	task automatic test_net_sharing();
		data_t n, h, x, y, rd, unused;
		resp_e resp, resp_x;
		n = random_word();
		h = random_word();
		x = random_word();
		y = random_word();
		net_access(1'b1, 32'h100, n, 4'hF, unused);
		axil_read(32'h100, 0, rd, resp);
		check_data("net write host read", n, rd);
		axil_write(32'h104, h, 4'hF, 0, resp);
		net_access(1'b0, 32'h104, '0, 4'hF, rd);
		check_data("host write net read", h, rd);
		// Both requesters start in the same cycle
		fork
			axil_write(32'h108, x, 4'hF, 0, resp_x);
			net_access(1'b1, 32'h10C, y, 4'hF, unused);
		join
		check_resp("contended host write", OKAY, resp_x);
		axil_read(32'h10C, 0, rd, resp);
		check_data("contended net data", y, rd);
		net_access(1'b0, 32'h108, '0, 4'hF, rd);
		check_data("contended host data", x, rd);
	endtask

	task automatic test_irq_capture();
		cause_t cause;
		data_t  rd;
		resp_e  resp;
		cause = cause_t'(lfsr_bits($bits(cause_t)));
		axil_write(CAUSE_BASE, 32'h0000_005A, 4'hF, 0, resp);
		check_resp("cause entry 0 write", OKAY, resp);
		@(posedge clk);
		irq_level_i <= 3'd3;
		irq_cause_i <= cause;
		@(posedge clk);
		irq_level_i <= 3'd0;                              // Level zero carries no interrupt
		irq_cause_i <= 8'hFF;
		@(posedge clk);
		irq_cause_i <= '0;
		axil_read(CAUSE_BASE + 32'd12, 0, rd, resp);
		check_resp("cause entry 3 read", OKAY, resp);
		check_cause("cause entry 3", cause, rd[7:0]);
		check_data("cause zero-extended", '0, rd & 32'hFFFF_FF00);
		axil_read(CAUSE_BASE, 0, rd, resp);
		check_cause("cause entry 0 kept", 8'h5A, rd[7:0]);
	endtask

	task automatic test_unmapped();
		data_t rd;
		resp_e resp;
		axil_write(UNMAPPED_BASE + 32'h10, random_word(), 4'hF, 0, resp);
		check_resp("unmapped write", SLVERR, resp);
		axil_read(UNMAPPED_BASE + 32'h10, 0, rd, resp);
		check_resp("unmapped read", SLVERR, resp);
		check_data("unmapped read data", '0, rd);
	endtask

	task automatic test_backpressure();
		data_t w, rd;
		resp_e resp;
		w = random_word();
		axil_write(SCRATCH_BASE + 32'h200, w, 4'hF, 6, resp);
		check_resp("held write response", OKAY, resp);
		axil_read(SCRATCH_BASE + 32'h200, 6, rd, resp);
		check_resp("held read response", OKAY, resp);
		check_data("held read data", w, rd);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		rst_i       = 1'b1;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b0;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b0;
		net_req_i   = 1'b0;
		net_we_i    = 1'b0;
		net_adr_i   = '0;
		net_wdata_i = '0;
		net_sel_i   = '0;
		irq_level_i = '0;
		irq_cause_i = '0;
		repeat (4) @(posedge clk);
		rst_i <= 1'b0;
		test_strobe_merge();
		test_region_independence();
		test_net_sharing();
		test_irq_capture();
		test_unmapped();
		test_backpressure();
		repeat (2) @(posedge clk);
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
common/node_bus_pkg.sv
common/node_map_pkg.sv
common/local_bus_if.sv
design/host_port/axil_slave.sv
design/node_region_router.sv
design/shared_ram/shared_ram_arbiter.sv
design/byte_ram.sv
design/irq_cause_table.sv
design/node_mem_top.sv
sim/node_mem_properties.sv
sim/tb_node_mem.sv

// ==== Makefile ====
SRCS := $(shell cat list.f)

obj_dir/Vtb_node_mem: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_node_mem -f list.f -Mdir obj_dir -o Vtb_node_mem

run: obj_dir/Vtb_node_mem
	obj_dir/Vtb_node_mem | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
